// File: design/archState.sv
`timescale 1ns/1ps
`default_nettype none

module archState #(
  parameter cpuPkg::addrT resetVector = '0  // Must be even
) (
  input  wire               clk,
  input  wire               arstN,
  input  wire cpuPkg::addrT pcNext,
  input  wire               halt,      // Halt opcode in the current word
  input  wire cpuPkg::flagT flagsIn,
  input  wire cpuPkg::flagT flagWrEn,  // One enable per flag
  output cpuPkg::addrT      pc,
  output cpuPkg::flagT      flags,
  output logic              halted
);

  ////////////////////////////////////////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= resetVector;
    end else if (!(halt || halted)) begin
      pc <= pcNext;  // Halt holds pc at its own address
    end
  end

  // Only the enabled flag bits take the new value
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= '0;
    end else begin
      flags <= (flagsIn & flagWrEn) | (flags & ~flagWrEn);
    end
  end

  // Sticky until the next reset
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      halted <= 1'b0;
    end else if (halt) begin
      halted <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////
  haltedSticky: assert property (@(posedge clk) disable iff (!arstN)
    halted |=> halted)
    else $error("archState halted fell without reset");

endmodule

`default_nettype wire

// File: design/branchIf.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded branch request, decoder to next-address logic
interface branchIf;
  import cpuPkg::*;

  condT   cond;       // Condition field
  offsetT offset;     // Signed word offset
  logic   branch;     // Either branch form
  logic   branchReg;  // Register form only
  dataT   rsData;     // Register value, supplied from outside the decoder

  modport decoder (
    output cond,
    output offset,
    output branch,
    output branchReg
  );

  modport target (
    input cond,
    input offset,
    input branch,
    input branchReg,
    input rsData
  );

endinterface

`default_nettype wire

// File: design/claAdder16.sv
`timescale 1ns/1ps
`default_nettype none

module claAdder16 (
  input  wire cpuPkg::addrT a,
  input  wire cpuPkg::addrT b,
  output cpuPkg::addrT      sum,
  output logic              carryOut
);
  import cpuPkg::*;

  addrT       gen;       // Bit generate
  addrT       prop;      // Bit propagate
  addrT       bitCarry;  // Carry into each bit
  logic [3:0] grpGen;    // Group generate, one per nibble
  logic [3:0] grpProp;   // Group propagate
  logic [4:0] grpCarry;  // Carry into each group, [4] is the carry out

  always_comb begin
    gen  = a & b;
    prop = a ^ b;

    ////////////////////////////////////////////////////////////////////////////
    // First level, per nibble
    ////////////////////////////////////////////////////////////////////////////
    for (int k = 0; k < 4; k++) begin
      grpProp[k] = &prop[4*k +: 4];  // All four bits pass a carry
      grpGen[k]  = gen[4*k+3]
                 | (prop[4*k+3] & gen[4*k+2])
                 | (prop[4*k+3] & prop[4*k+2] & gen[4*k+1])
                 | (prop[4*k+3] & prop[4*k+2] & prop[4*k+1] & gen[4*k]);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Second level, across the four groups
    ////////////////////////////////////////////////////////////////////////////
    grpCarry[0] = 1'b0;  // No carry in
    grpCarry[1] = grpGen[0];
    grpCarry[2] = grpGen[1] | (grpProp[1] & grpGen[0]);
    grpCarry[3] = grpGen[2] | (grpProp[2] & grpGen[1])
                | (grpProp[2] & grpProp[1] & grpGen[0]);
    grpCarry[4] = grpGen[3] | (grpProp[3] & grpGen[2])
                | (grpProp[3] & grpProp[2] & grpGen[1])
                | (grpProp[3] & grpProp[2] & grpProp[1] & grpGen[0]);

    // Bit carries inside each group, from its group carry
    for (int k = 0; k < 4; k++) begin
      bitCarry[4*k]   = grpCarry[k];
      bitCarry[4*k+1] = gen[4*k] | (prop[4*k] & grpCarry[k]);
      bitCarry[4*k+2] = gen[4*k+1] | (prop[4*k+1] & gen[4*k])
                      | (prop[4*k+1] & prop[4*k] & grpCarry[k]);
      bitCarry[4*k+3] = gen[4*k+2] | (prop[4*k+2] & gen[4*k+1])
                      | (prop[4*k+2] & prop[4*k+1] & gen[4*k])
                      | (prop[4*k+2] & prop[4*k+1] & prop[4*k] & grpCarry[k]);
    end

    sum      = prop ^ bitCarry;  // Wraps past 16 bits
    carryOut = grpCarry[4];

    // Both lookahead levels together must match a plain add
    assert ({carryOut, sum} == ({1'b0, a} + {1'b0, b}))
      else $error("claAdder16 %h + %h gave %b_%h", a, b, carryOut, sum);
  end

endmodule

`default_nettype wire

// File: design/cpuPkg.sv
`default_nettype none

package cpuPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////////////////////////////////////////
  typedef logic [15:0]        addrT;    // Byte address of an instruction
  typedef logic [15:0]        dataT;    // Register file word
  typedef logic [15:0]        instrT;   // Raw instruction word
  typedef logic signed [8:0]  offsetT;  // Branch offset in words
  typedef logic [3:0]         regIdxT;  // Register number
  typedef logic [2:0]         flagT;    // Z, V, N

  // Instructions are one 16-bit word, so 2 bytes apart
  localparam addrT instrStep = 16'h0002;

  // Flag bit positions
  localparam int flagZ = 2;
  localparam int flagV = 1;
  localparam int flagN = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////
  // Only the control flow opcodes, all others fall through to PC+2
  typedef enum logic [3:0] {
    opBranch    = 4'b1100,  // B ccc, offset
    opBranchReg = 4'b1101,  // BR ccc, rs
    opHalt      = 4'b1111   // Stop fetching
  } opcodeT;

  typedef enum logic [2:0] {
    condNe     = 3'b000,  // Z clear
    condEq     = 3'b001,  // Z set
    condGt     = 3'b010,  // Z and N clear
    condLt     = 3'b011,  // N set
    condGe     = 3'b100,  // Z set or N clear
    condLe     = 3'b101,  // Z or N set
    condOv     = 3'b110,  // V set
    condAlways = 3'b111   // Unconditional
  } condT;

endpackage

`default_nettype wire

// File: design/instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
  input  wire cpuPkg::instrT instr,
  output cpuPkg::regIdxT     rsIdx,
  output logic               halt,
  branchIf.decoder           br
);
  import cpuPkg::*;

  opcodeT opcode;  // Top nibble of the word

  always_comb begin
    ////////////////////////////////////////////////////////////////////////////
    // Field extraction
    ////////////////////////////////////////////////////////////////////////////
    opcode    = opcodeT'(instr[15:12]);
    br.cond   = condT'(instr[11:9]);
    br.offset = offsetT'(instr[8:0]);  // Only meaningful for B
    rsIdx     = instr[7:4];            // Only meaningful for BR

    // Default is a plain instruction, PC+2
    br.branch    = 1'b0;
    br.branchReg = 1'b0;
    halt         = 1'b0;

    case (opcode)
      opBranch: begin
        br.branch = 1'b1;
      end
      opBranchReg: begin
        br.branch    = 1'b1;  // Shares the condition check with B
        br.branchReg = 1'b1;
      end
      opHalt: begin
        halt = 1'b1;
      end
      default: begin
        // ALU, memory and others, no control flow change
      end
    endcase

    // A halt must never also move the pc elsewhere
    assert (!(halt && br.branch))
      else $error("instrDecode halt and branch both raised for %h", instr);
  end

endmodule

`default_nettype wire

// File: design/pcControl.sv
`timescale 1ns/1ps
`default_nettype none

module pcControl (
  input  wire cpuPkg::addrT pc,
  input  wire cpuPkg::flagT flags,
  branchIf.target           br,
  output cpuPkg::addrT      pcNext
);
  import cpuPkg::*;

  addrT pcPlus2;       // Sequential address
  addrT offsetBytes;   // Word offset as a byte offset
  addrT branchTarget;  // PC+2 plus offset
  logic condTrue;      // Condition holds on current flags

  // Sign extend and shift left by one
  assign offsetBytes = {{6{br.offset[8]}}, br.offset, 1'b0};

  claAdder16 seqAdder (
    .a        (pc),
    .b        (instrStep),
    .sum      (pcPlus2),
    .carryOut ()          // Wraparound intended
  );

  claAdder16 branchAdder (
    .a        (pcPlus2),
    .b        (offsetBytes),
    .sum      (branchTarget),
    .carryOut ()
  );

  ////////////////////////////////////////////////////////////////////////////
  // Condition evaluation
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    unique case (br.cond)
      condNe:     condTrue = ~flags[flagZ];
      condEq:     condTrue = flags[flagZ];
      condGt:     condTrue = ~flags[flagZ] & ~flags[flagN];
      condLt:     condTrue = flags[flagN];
      condGe:     condTrue = flags[flagZ] | ~flags[flagN];
      condLe:     condTrue = flags[flagZ] | flags[flagN];
      condOv:     condTrue = flags[flagV];
      condAlways: condTrue = 1'b1;
    endcase
  end

  // Taken BR goes to the register, taken B to the target
  assign pcNext = (br.branch && condTrue) ? (br.branchReg ? br.rsData : branchTarget)
                                          : pcPlus2;

endmodule

`default_nettype wire

// File: design/pcFetch.sv
`timescale 1ns/1ps
`default_nettype none

module pcFetch #(
  parameter cpuPkg::addrT resetVector = '0
) (
  input  wire                 clk,
  input  wire                 arstN,
  input  wire cpuPkg::instrT  instr,     // Word at the current pc
  output cpuPkg::addrT        pc,
  output cpuPkg::regIdxT      rsIdx,     // To the register file
  input  wire cpuPkg::dataT   rsData,    // Same cycle read data
  input  wire cpuPkg::flagT   flagsIn,   // From the ALU
  input  wire cpuPkg::flagT   flagWrEn,
  output logic                halted
);
  import cpuPkg::*;

  addrT pcNext;  // Next address, purely combinational
  flagT flags;   // Flags as of the last edge
  logic halt;    // Decoded halt level

  branchIf br ();

  // Register value enters the branch bundle here
  assign br.rsData = rsData;

  ////////////////////////////////////////////////////////////////////////////
  // Decode and next address
  ////////////////////////////////////////////////////////////////////////////
  instrDecode uDecode (
    .instr (instr),
    .rsIdx (rsIdx),
    .halt  (halt),
    .br    (br.decoder)
  );

  pcControl uPcControl (
    .pc     (pc),
    .flags  (flags),
    .br     (br.target),
    .pcNext (pcNext)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Architectural state
  ////////////////////////////////////////////////////////////////////////////
  archState #(
    .resetVector (resetVector)
  ) uState (
    .clk      (clk),
    .arstN    (arstN),
    .pcNext   (pcNext),
    .halt     (halt),
    .flagsIn  (flagsIn),
    .flagWrEn (flagWrEn),
    .pc       (pc),
    .flags    (flags),
    .halted   (halted)
  );

endmodule

`default_nettype wire

// File: pcFetch.f
design/cpuPkg.sv
design/branchIf.sv
design/claAdder16.sv
design/instrDecode.sv
design/pcControl.sv
design/archState.sv
design/pcFetch.sv
testbench/pcFetchTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the pcFetch testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f pcFetch.f \
  --top-module pcFetchTb -o pcFetchSim \
  && ./obj_dir/pcFetchSim > sim.log 2>&1 ; cat sim.log 2>/dev/null
grep -qx "Test passed" sim.log && echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }

// File: testbench/pcFetchTb.sv
`timescale 1ns/1ps
`default_nettype none

module pcFetchTb;

  logic        clk;
  logic        arstN;
  logic [15:0] instr;
  logic [15:0] pc;
  logic [3:0]  rsIdx;
  logic [15:0] rsData;
  logic [2:0]  flagsIn;
  logic [2:0]  flagWrEn;
  logic        halted;

  integer      seed = 32'hb583;
  int          errCount = 0;     // Failed checks over the whole run
  int          testsFailed = 0;
  logic [15:0] expPc;            // Model pc, flags and halt state
  logic [2:0]  expFlags;
  logic        expHalted;

  pcFetch #(.resetVector(16'h0000)) DUT (
    .clk(clk), .arstN(arstN), .instr(instr), .pc(pc), .rsIdx(rsIdx),
    .rsData(rsData), .flagsIn(flagsIn), .flagWrEn(flagWrEn), .halted(halted)
  );

  always #2 clk = ~clk;  // 4 ns period

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [15:0] nextPc(input logic [15:0] curPc, input logic [15:0] word,
                                         input logic [2:0] fl, input logic [15:0] regVal);
    int   offWords;
    logic z, v, n, taken;
    z = fl[2];
    v = fl[1];
    n = fl[0];
    offWords = $signed(word[8:0]);  // Signed word offset
    case (word[11:9])
      3'd0:    taken = !z;
      3'd1:    taken = z;
      3'd2:    taken = !z && !n;
      3'd3:    taken = n;
      3'd4:    taken = z || !n;
      3'd5:    taken = z || n;
      3'd6:    taken = v;
      default: taken = 1'b1;
    endcase
    if (taken && word[15:12] == 4'hC) return curPc + 16'd2 + 16'(offWords * 2);
    if (taken && word[15:12] == 4'hD) return regVal;
    return curPc + 16'd2;  // Not taken or not a branch
  endfunction

  // Pre-edge inputs and model flags decide what the edge does
  always @(posedge clk) begin
    if (!arstN) begin
      expPc     = 16'h0000;
      expFlags  = 3'b000;
      expHalted = 1'b0;
    end else begin
      assert (pc == expPc) else begin
        $display("ERROR pc: got %h expected %h", pc, expPc);
        errCount++;
      end
      assert (halted == expHalted) else begin
        $display("ERROR halted: got %h expected %h", halted, expHalted);
        errCount++;
      end
      assert (rsIdx == instr[7:4]) else begin
        $display("ERROR rsIdx: got %h expected %h", rsIdx, instr[7:4]);
        errCount++;
      end
      if (!expHalted && instr[15:12] != 4'hF) expPc = nextPc(expPc, instr, expFlags, rsData);
      if (instr[15:12] == 4'hF) expHalted = 1'b1;
      for (int i = 0; i < 3; i++) if (flagWrEn[i]) expFlags[i] = flagsIn[i];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [15:0] plainWord();
    logic [15:0] w;
    w = 16'($random(seed));
    if (w[15:12] inside {4'hC, 4'hD, 4'hF}) w[15] = 1'b0;  // Move off control flow
    return w;
  endfunction

  // About a third B, a sixth BR, the rest plain
  function automatic logic [15:0] mixedWord();
    int          sel;
    logic [15:0] w;
    sel = int'({$random(seed)} % 6);
    w   = 16'($random(seed));
    if (sel < 2) return {4'hC, w[11:0]};
    if (sel == 2) return {4'hD, w[11:0]};
    return plainWord();
  endfunction

  task automatic drive(input logic [15:0] word, input logic [2:0] fIn, input logic [2:0] fEn);
    @(posedge clk);
    instr    <= word;
    rsData   <= 16'($random(seed)) & 16'hFFFE;  // Even register targets
    flagsIn  <= fIn;
    flagWrEn <= fEn;
  endtask

  task automatic resetDut();
    @(posedge clk);
    arstN <= 1'b0;
    instr <= 16'h0000;
    repeat (8) @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    assert (pc == 16'h0000) else begin
      $display("ERROR pc after reset: got %h expected %h", pc, 16'h0000);
      errCount++;
    end
    assert (halted == 1'b0) else begin
      $display("ERROR halted after reset: got %h expected %h", halted, 1'b0);
      errCount++;
    end
  endtask

  task automatic finishTest(input string name, input int errsBefore);
    repeat (2) @(posedge clk);  // Last drive is compared two edges later
    @(negedge clk);
    if (errCount == errsBefore) begin
      $display("%s: PASS", name);
    end else begin
      $display("%s: FAIL with %0d errors", name, errCount - errsBefore);
      testsFailed++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    logic [15:0] haltAddr;
    logic        sawTop;
    int          n;
    int          startErr;
    clk      = 1'b0;
    arstN    = 1'b0;
    instr    = 16'h0000;
    rsData   = 16'h0000;
    flagsIn  = 3'b000;
    flagWrEn = 3'b000;
    resetDut();

    startErr = errCount;  // Test 1 runs plain words until pc wraps
    sawTop = 1'b0;
    for (n = 0; n < 40000 && !(sawTop && pc == 16'h0000); n++) begin
      drive(plainWord(), 3'($random(seed)), 3'($random(seed)));
      if (pc == 16'hFFFE) sawTop = 1'b1;
    end
    if (!(sawTop && pc == 16'h0000)) begin
      $display("Timeout: pc did not wrap from FFFE to 0000 within 40000 cycles");
      errCount++;
    end
    finishTest("Test 1 sequential and wrap", startErr);

    startErr = errCount;  // Test 2 tries every condition on every flag value
    for (int f = 0; f < 8; f++) begin
      drive(plainWord(), 3'(f), 3'b111);
      for (int c = 0; c < 8; c++) begin
        drive({4'hC, 3'(c), c[0], 8'($random(seed))}, 3'b000, 3'b000);
      end
    end
    finishTest("Test 2 conditional branches", startErr);

    startErr = errCount;  // Test 3 mixes register branches with plain words
    for (n = 0; n < 300; n++) begin
      drive(({$random(seed)} % 3 != 0) ? {4'hD, 12'($random(seed))} : plainWord(),
            3'($random(seed)), 3'($random(seed)));
    end
    finishTest("Test 3 register branches", startErr);

    startErr = errCount;  // Test 4 follows each partial flag write with a branch
    for (n = 0; n < 200; n++) begin
      drive(plainWord(), 3'($random(seed)), 3'($random(seed)));
      drive({3'b110, 1'($random(seed)), 12'($random(seed))}, 3'b000, 3'b000);
    end
    finishTest("Test 4 partial flag writes", startErr);

    startErr = errCount;  // Test 5 halts, holds and then resets
    repeat (20) drive(mixedWord(), 3'($random(seed)), 3'($random(seed)));
    drive({4'hF, 12'($random(seed))}, 3'b000, 3'b000);
    @(negedge clk);
    haltAddr = pc;  // Address of the halt word
    for (n = 0; n < 10 && !halted; n++) drive(mixedWord(), 3'($random(seed)), 3'b000);
    if (!halted) begin
      $display("Timeout: halted was not set within 10 cycles of the halt instruction");
      errCount++;
    end
    repeat (20) drive(mixedWord(), 3'($random(seed)), 3'($random(seed)));
    @(negedge clk);
    assert (pc == haltAddr) else begin
      $display("ERROR pc: got %h expected %h", pc, haltAddr);
      errCount++;
    end
    resetDut();
    finishTest("Test 5 halt and reset", startErr);

    $display("Tests: %0d ok, %0d failing, %0d check errors", 5 - testsFailed, testsFailed,
             errCount);
    if (errCount == 0 && testsFailed == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
